// File: source/rv_pkg.sv
// shared widths, reset address and enums of the RV32I multicycle core
// opcode_t values are the raw 7-bit major opcode field, so decode can cast
// an instruction field straight onto it. Values outside the enum mean an
// unknown instruction, which retires as a no-op.
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_idx_w  = 5;
    localparam logic [xlen-1:0] reset_addr = '0;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op,
        pass_imm,
        link
    } alu_op_t;

    typedef enum logic [2:0] {
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu,
        none
    } branch_op_t;

    typedef enum logic [1:0] {
        byte_size,
        half_size,
        word_size
    } mem_size_t;

    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        mem_access,
        write_back
    } core_state_t;

endpackage

// File: source/rv_regfile.sv
// 32 x 32-bit register file, x0 reads as zero and ignores writes
// reads are asynchronous, the write lands on the rising clock edge
// contents are undefined after reset
`timescale 1ns/100ps

module rv_regfile (
    input  logic                       clk,
    input  logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
    input  logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
    input  logic [rv_pkg::reg_idx_w-1:0] rd_idx,
    input  logic                       rd_we,
    input  logic [rv_pkg::xlen-1:0]    rd_data,
    output logic [rv_pkg::xlen-1:0]    rs1_val,
    output logic [rv_pkg::xlen-1:0]    rs2_val
);

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:(2**rv_pkg::reg_idx_w)-1];

    always_ff @(posedge clk) begin
        if (rd_we && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: source/rv_decode.sv
// combinational RV32I decoder
// unknown opcodes give rd_write low, branch_op none and a zero immediate
// mem_size and load_unsigned follow funct3 for every opcode; only
// loads and stores look at them
`timescale 1ns/100ps

module rv_decode (
    input  logic [rv_pkg::xlen-1:0]      instr,
    output rv_pkg::opcode_t              opcode,
    output logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
    output logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
    output logic [rv_pkg::reg_idx_w-1:0] rd_idx,
    output logic [rv_pkg::xlen-1:0]      imm,
    output rv_pkg::alu_op_t              alu_op,
    output logic                         alu_src_imm,
    output logic                         alu_src_pc,
    output rv_pkg::branch_op_t           branch_op,
    output rv_pkg::mem_size_t            mem_size,
    output logic                         load_unsigned,
    output logic                         rd_write
);

    logic [2:0]              funct3;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;

    // funct3 plus the funct7 alternate bit onto one ALU operation
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::sub : rv_pkg::add;
            3'b001:  return rv_pkg::sll;
            3'b010:  return rv_pkg::slt;
            3'b011:  return rv_pkg::sltu;
            3'b100:  return rv_pkg::xor_op;
            3'b101:  return alt ? rv_pkg::sra : rv_pkg::srl;
            3'b110:  return rv_pkg::or_op;
            default: return rv_pkg::and_op;
        endcase
    endfunction

    assign opcode  = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rd_idx  = instr[11:7];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign mem_size = (funct3[1:0] == 2'b00) ? rv_pkg::byte_size :
                      (funct3[1:0] == 2'b01) ? rv_pkg::half_size : rv_pkg::word_size;
    assign load_unsigned = funct3[2];

    always_comb begin
        imm         = '0;
        alu_op      = rv_pkg::add;
        alu_src_imm = 1'b0;
        alu_src_pc  = 1'b0;
        branch_op   = rv_pkg::none;
        rd_write    = 1'b0;
        case (opcode)
            rv_pkg::op: begin
                alu_op   = alu_sel(funct3, instr[30]);
                rd_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                // bit 30 only selects srai; addi keeps it as immediate
                imm         = imm_i;
                alu_op      = alu_sel(funct3, instr[30] && (funct3 == 3'b101));
                alu_src_imm = 1'b1;
                rd_write    = 1'b1;
            end
            rv_pkg::load: begin
                imm         = imm_i;
                alu_src_imm = 1'b1;
                rd_write    = 1'b1;
            end
            rv_pkg::store: begin
                imm         = imm_s;
                alu_src_imm = 1'b1;
            end
            rv_pkg::branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  branch_op = rv_pkg::beq;
                    3'b001:  branch_op = rv_pkg::bne;
                    3'b100:  branch_op = rv_pkg::blt;
                    3'b101:  branch_op = rv_pkg::bge;
                    3'b110:  branch_op = rv_pkg::bltu;
                    3'b111:  branch_op = rv_pkg::bgeu;
                    default: branch_op = rv_pkg::none;
                endcase
            end
            rv_pkg::jal: begin
                imm      = imm_j;
                alu_op   = rv_pkg::link;
                rd_write = 1'b1;
            end
            rv_pkg::jalr: begin
                imm      = imm_i;
                alu_op   = rv_pkg::link;
                rd_write = 1'b1;
            end
            rv_pkg::lui: begin
                imm         = imm_u;
                alu_op      = rv_pkg::pass_imm;
                alu_src_imm = 1'b1;
                rd_write    = 1'b1;
            end
            rv_pkg::auipc: begin
                imm         = imm_u;
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                rd_write    = 1'b1;
            end
            default: begin
                rd_write = 1'b0;
            end
        endcase
    end

endmodule

// File: source/rv_execute.sv
// ALU, branch compare and next pc, all combinational
// shifts use the low five bits of the second operand
// the JALR target has bit 0 cleared, as the ISA requires
`timescale 1ns/100ps

module rv_execute (
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_val,
    input  logic [rv_pkg::xlen-1:0] rs2_val,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic                    alu_src_imm,
    input  logic                    alu_src_pc,
    input  rv_pkg::branch_op_t      branch_op,
    input  rv_pkg::opcode_t         opcode,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] next_pc
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [4:0]              shamt;
    logic                    taken;

    assign op_a     = alu_src_pc ? pc : rs1_val;
    assign op_b     = alu_src_imm ? imm : rs2_val;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + rv_pkg::xlen'(4);

    always_comb begin
        case (alu_op)
            rv_pkg::sub:      alu_result = op_a - op_b;
            rv_pkg::sll:      alu_result = op_a << shamt;
            rv_pkg::slt:      alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::sltu:     alu_result = {31'b0, op_a < op_b};
            rv_pkg::xor_op:   alu_result = op_a ^ op_b;
            rv_pkg::srl:      alu_result = op_a >> shamt;
            rv_pkg::sra:      alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::or_op:    alu_result = op_a | op_b;
            rv_pkg::and_op:   alu_result = op_a & op_b;
            rv_pkg::pass_imm: alu_result = imm;
            rv_pkg::link:     alu_result = pc_plus4;
            default:          alu_result = op_a + op_b;
        endcase
    end

    // branch compare always on the register values
    always_comb begin
        case (branch_op)
            rv_pkg::beq:  taken = (rs1_val == rs2_val);
            rv_pkg::bne:  taken = (rs1_val != rs2_val);
            rv_pkg::blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
            rv_pkg::bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::bltu: taken = (rs1_val < rs2_val);
            rv_pkg::bgeu: taken = (rs1_val >= rs2_val);
            default:      taken = 1'b0;
        endcase
    end

    always_comb begin
        if (opcode == rv_pkg::jalr) begin
            next_pc = (rs1_val + imm) & ~rv_pkg::xlen'(1);
        end else if (taken || (opcode == rv_pkg::jal)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

// File: source/rv_result.sv
// store lane placement and byte mask, load lane extraction, write-back mux
// addr_low selects the byte lane; word accesses ignore it
// store_wmask is zero for anything but a store
`timescale 1ns/100ps

module rv_result (
    input  rv_pkg::opcode_t         opcode,
    input  rv_pkg::mem_size_t       mem_size,
    input  logic                    load_unsigned,
    input  logic [1:0]              addr_low,
    input  logic [rv_pkg::xlen-1:0] rs2_val,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] load_word,
    output logic [rv_pkg::xlen-1:0] store_data,
    output logic [3:0]              store_wmask,
    output logic [rv_pkg::xlen-1:0] rd_data
);

    logic [7:0]              load_byte;
    logic [15:0]             load_half;
    logic [rv_pkg::xlen-1:0] load_val;

    // replicated data, the mask picks the lane that is written
    always_comb begin
        case (mem_size)
            rv_pkg::byte_size: begin
                store_data  = {4{rs2_val[7:0]}};
                store_wmask = 4'b0001 << addr_low;
            end
            rv_pkg::half_size: begin
                store_data  = {2{rs2_val[15:0]}};
                store_wmask = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_data  = rs2_val;
                store_wmask = 4'b1111;
            end
        endcase
        if (opcode != rv_pkg::store) begin
            store_wmask = 4'b0000;
        end
    end

    assign load_byte = load_word[8*addr_low +: 8];
    assign load_half = load_word[16*addr_low[1] +: 16];

    always_comb begin
        case (mem_size)
            rv_pkg::byte_size: begin
                load_val = {{24{load_byte[7] & ~load_unsigned}}, load_byte};
            end
            rv_pkg::half_size: begin
                load_val = {{16{load_half[15] & ~load_unsigned}}, load_half};
            end
            default: begin
                load_val = load_word;
            end
        endcase
    end

    assign rd_data = (opcode == rv_pkg::load) ? load_val : alu_result;

endmodule

// File: source/rv_core.sv
// multicycle RV32I core over one shared memory port
// mem_req stays high with address, data and mask stable until mem_ack;
// mem_rdata is sampled only in the acknowledge cycle. mem_addr is word
// aligned and mem_wmask selects bytes, zero mask means read.
// misaligned accesses are not trapped, unknown opcodes retire as no-ops
`timescale 1ns/100ps

module rv_core (
    input  logic                    clk,
    input  logic                    resetn,
    output logic                    mem_req,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    output logic [3:0]              mem_wmask,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    input  logic                    mem_ack
);

    rv_pkg::core_state_t state;

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] instr_q;
    logic [rv_pkg::xlen-1:0] alu_q;
    logic [rv_pkg::xlen-1:0] load_q;

    // decode outputs
    rv_pkg::opcode_t              opcode;
    logic [rv_pkg::reg_idx_w-1:0] rs1_idx;
    logic [rv_pkg::reg_idx_w-1:0] rs2_idx;
    logic [rv_pkg::reg_idx_w-1:0] rd_idx;
    logic [rv_pkg::xlen-1:0]      imm;
    rv_pkg::alu_op_t              alu_op;
    logic                         alu_src_imm;
    logic                         alu_src_pc;
    rv_pkg::branch_op_t           branch_op;
    rv_pkg::mem_size_t            mem_size;
    logic                         load_unsigned;
    logic                         rd_write;

    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] store_data;
    logic [3:0]              store_wmask;
    logic [rv_pkg::xlen-1:0] rd_data;
    logic                    rd_we;
    logic                    is_mem;

    assign is_mem = (opcode == rv_pkg::load) || (opcode == rv_pkg::store);
    assign rd_we  = (state == rv_pkg::write_back) && rd_write && (rd_idx != '0);

    // memory port, fetch uses pc, data accesses the latched ALU result
    assign mem_addr  = (state == rv_pkg::fetch) ? pc : {alu_q[rv_pkg::xlen-1:2], 2'b00};
    assign mem_wdata = store_data;
    assign mem_wmask = (state == rv_pkg::mem_access) ? store_wmask : 4'b0000;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= rv_pkg::fetch;
            pc      <= rv_pkg::reset_addr;
            mem_req <= 1'b0;
        end else begin
            case (state)
                rv_pkg::fetch: begin
                    if (mem_req && mem_ack) begin
                        instr_q <= mem_rdata;
                        mem_req <= 1'b0;
                        state   <= rv_pkg::decode;
                    end else begin
                        mem_req <= 1'b1;
                    end
                end
                rv_pkg::decode: begin
                    state <= rv_pkg::execute;
                end
                rv_pkg::execute: begin
                    alu_q <= alu_result;
                    if (is_mem) begin
                        mem_req <= 1'b1;
                        state   <= rv_pkg::mem_access;
                    end else begin
                        state <= rv_pkg::write_back;
                    end
                end
                rv_pkg::mem_access: begin
                    if (mem_ack) begin
                        load_q  <= mem_rdata;
                        mem_req <= 1'b0;
                        state   <= rv_pkg::write_back;
                    end
                end
                rv_pkg::write_back: begin
                    // next fetch request goes out right away
                    pc      <= next_pc;
                    mem_req <= 1'b1;
                    state   <= rv_pkg::fetch;
                end
                default: begin
                    mem_req <= 1'b0;
                    state   <= rv_pkg::fetch;
                end
            endcase
        end
    end

    rv_regfile i_regfile (
        .clk     (clk),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx),
        .rd_we   (rd_we),
        .rd_data (rd_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rv_decode i_decode (
        .instr         (instr_q),
        .opcode        (opcode),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rd_idx        (rd_idx),
        .imm           (imm),
        .alu_op        (alu_op),
        .alu_src_imm   (alu_src_imm),
        .alu_src_pc    (alu_src_pc),
        .branch_op     (branch_op),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .rd_write      (rd_write)
    );

    rv_execute i_execute (
        .pc          (pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .alu_src_pc  (alu_src_pc),
        .branch_op   (branch_op),
        .opcode      (opcode),
        .alu_result  (alu_result),
        .next_pc     (next_pc)
    );

    // operands hold still from decode to write_back, so the live ALU
    // result is valid for lane selection in every later state
    rv_result i_result (
        .opcode        (opcode),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .addr_low      (alu_result[1:0]),
        .rs2_val       (rs2_val),
        .alu_result    (alu_result),
        .load_word     (load_q),
        .store_data    (store_data),
        .store_wmask   (store_wmask),
        .rd_data       (rd_data)
    );

endmodule

// File: sim/tb_memory.sv
// behavioral memory for the core handshake, 256 words from address 0
// acknowledge comes 0 to 3 cycles after the request is seen
// delays come from $urandom with a fixed seed
// every write is published through write_seen and the wr_* variables
`timescale 1ns/100ps

module tb_memory (
    input  logic        clk,
    input  logic        req,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wmask,
    output logic [31:0] rdata,
    output logic        ack
);

    logic [31:0] mem [0:255];
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_mask;
    event        write_seen;
    int          wait_left;
    logic        busy;

    initial begin
        void'($urandom(32'hf7a8_2128));
        // fill depends on the full word address
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i << 2);
        end
        ack   = 1'b0;
        rdata = '0;
        busy  = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ack) begin
                // transfer done, core drops req on this edge
                ack  = 1'b0;
            end else if (req) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    rdata = mem[addr[9:2]];
                    if (wmask != 4'b0000) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wmask[b]) begin
                                mem[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                            end
                        end
                        wr_addr = addr;
                        wr_data = wdata;
                        wr_mask = wmask;
                        -> write_seen;
                    end
                    ack  = 1'b1;
                    busy = 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

// File: sim/tb_core.sv
// testbench for rv_core, runs a hand assembled RV32I program
// results are checked only through the stores the program makes
// data area at 0x200, program ends spinning on a jal to itself
`timescale 1ns/100ps

module tb_core;

    localparam int reset_cycles = 4;

    logic        clk;
    logic        resetn;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_rdata;
    logic        mem_ack;

    logic [31:0] prog [0:255];
    int          prog_len;
    logic [31:0] exp_addr [0:63];
    logic [31:0] exp_data [0:63];
    logic [3:0]  exp_mask [0:63];
    int          n_stores;
    int          writes_seen;

    rv_core i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    tb_memory i_mem (
        .clk   (clk),
        .req   (mem_req),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .wmask (mem_wmask),
        .rdata (mem_rdata),
        .ack   (mem_ack)
    );

    always #5 clk = ~clk;

    // instruction formats
    function automatic logic [31:0] itype(input logic [31:0] imm, input logic [31:0] rs1,
                                          input logic [31:0] f3, input logic [31:0] rd,
                                          input logic [31:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] rtype(input logic [31:0] f7, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3,
                                          input logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] stype(input logic [31:0] imm, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] btype(input logic [31:0] imm, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype(input logic [31:0] imm, input logic [31:0] rd,
                                          input logic [31:0] opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] jtype(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len = prog_len + 1;
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] m);
        exp_addr[n_stores] = a;
        exp_data[n_stores] = d;
        exp_mask[n_stores] = m;
        n_stores = n_stores + 1;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        emit(itype(32'h200, 0, 0, 1, 7'h13));      // x1 = data base
        emit(itype(-7, 0, 0, 2, 7'h13));
        emit(itype(5, 0, 0, 3, 7'h13));
        emit(rtype(0, 3, 2, 0, 4));                // add
        emit(stype(0, 4, 1, 2));
        emit(rtype(7'h20, 2, 3, 0, 4));            // sub
        emit(stype(4, 4, 1, 2));
        emit(rtype(0, 3, 2, 7, 4));                // and
        emit(stype(8, 4, 1, 2));
        emit(rtype(0, 3, 2, 6, 4));                // or
        emit(stype(12, 4, 1, 2));
        emit(rtype(0, 3, 2, 4, 4));                // xor
        emit(stype(16, 4, 1, 2));
        emit(rtype(0, 3, 2, 2, 4));                // slt
        emit(stype(20, 4, 1, 2));
        emit(rtype(0, 3, 2, 3, 4));                // sltu
        emit(stype(24, 4, 1, 2));
        emit(itype(32'h401, 2, 5, 4, 7'h13));      // srai by 1
        emit(stype(28, 4, 1, 2));
        emit(itype(28, 2, 5, 4, 7'h13));           // srli by 28
        emit(stype(32, 4, 1, 2));
        emit(itype(4, 3, 1, 4, 7'h13));            // slli by 4
        emit(stype(36, 4, 1, 2));
        emit(itype(-1, 3, 4, 4, 7'h13));           // xori
        emit(stype(40, 4, 1, 2));
        emit(utype(32'h12345, 5, 7'h37));          // lui
        emit(stype(44, 5, 1, 2));
        emit(utype(32'h1, 5, 7'h17));              // auipc at 0x6c
        emit(stype(48, 5, 1, 2));
        emit(utype(32'h87654, 6, 7'h37));
        emit(itype(32'h321, 6, 0, 6, 7'h13));
        emit(stype(32'h35, 6, 1, 0));              // sb lane 1
        emit(stype(32'h3a, 6, 1, 1));              // sh upper half
        emit(stype(32'h3c, 6, 1, 2));
        emit(itype(32'h3f, 1, 0, 7, 7'h03));       // lb
        emit(stype(32'h40, 7, 1, 2));
        emit(itype(32'h3f, 1, 4, 7, 7'h03));       // lbu
        emit(stype(32'h44, 7, 1, 2));
        emit(itype(32'h3e, 1, 1, 7, 7'h03));       // lh
        emit(stype(32'h48, 7, 1, 2));
        emit(itype(32'h3e, 1, 5, 7, 7'h03));       // lhu
        emit(stype(32'h4c, 7, 1, 2));
        emit(itype(32'h2c, 1, 2, 7, 7'h03));       // lw
        emit(stype(32'h50, 7, 1, 2));
        // branches on -7 and 5, marker store follows each
        emit(btype(8, 3, 2, 0));
        emit(stype(32'h54, 3, 1, 2));
        emit(btype(8, 3, 2, 1));
        emit(stype(32'h58, 3, 1, 2));
        emit(btype(8, 3, 2, 4));
        emit(stype(32'h5c, 3, 1, 2));
        emit(btype(8, 3, 2, 5));
        emit(stype(32'h60, 3, 1, 2));
        emit(btype(8, 3, 2, 6));
        emit(stype(32'h64, 3, 1, 2));
        emit(btype(8, 3, 2, 7));
        emit(stype(32'h68, 3, 1, 2));
        emit(btype(8, 3, 3, 0));
        emit(stype(32'h6c, 3, 1, 2));
        emit(btype(8, 3, 3, 1));
        emit(stype(32'h70, 3, 1, 2));
        emit(jtype(12, 8));                        // jal at 0xf0
        emit(stype(32'h74, 3, 1, 2));
        emit(stype(32'h78, 3, 1, 2));
        emit(stype(32'h7c, 8, 1, 2));
        emit(itype(32'h110, 0, 0, 9, 7'h13));
        emit(itype(0, 9, 0, 10, 7'h67));           // jalr at 0x104
        emit(stype(32'h80, 3, 1, 2));
        emit(stype(32'h84, 3, 1, 2));
        emit(stype(32'h88, 10, 1, 2));
        emit(itype(123, 0, 0, 0, 7'h13));          // write to x0
        emit(stype(32'h8c, 0, 1, 2));
        // ordered compares again with the operands swapped
        emit(btype(8, 2, 3, 4));
        emit(stype(32'h90, 3, 1, 2));
        emit(btype(8, 2, 3, 5));
        emit(stype(32'h94, 3, 1, 2));
        emit(btype(8, 2, 3, 6));
        emit(stype(32'h98, 3, 1, 2));
        emit(btype(8, 2, 3, 7));
        emit(stype(32'h9c, 3, 1, 2));
        emit(jtype(0, 0));                         // spin
    endtask

    task automatic build_expected();
        expect_store(32'h200, 32'hffff_fffe, 4'hf);
        expect_store(32'h204, 32'h0000_000c, 4'hf);
        expect_store(32'h208, 32'h0000_0001, 4'hf);
        expect_store(32'h20c, 32'hffff_fffd, 4'hf);
        expect_store(32'h210, 32'hffff_fffc, 4'hf);
        expect_store(32'h214, 32'h0000_0001, 4'hf);
        expect_store(32'h218, 32'h0000_0000, 4'hf);
        expect_store(32'h21c, 32'hffff_fffc, 4'hf);
        expect_store(32'h220, 32'h0000_000f, 4'hf);
        expect_store(32'h224, 32'h0000_0050, 4'hf);
        expect_store(32'h228, 32'hffff_fffa, 4'hf);
        expect_store(32'h22c, 32'h1234_5000, 4'hf);
        expect_store(32'h230, 32'h0000_106c, 4'hf);
        expect_store(32'h234, 32'h2121_2121, 4'b0010);
        expect_store(32'h238, 32'h4321_4321, 4'b1100);
        expect_store(32'h23c, 32'h8765_4321, 4'hf);
        expect_store(32'h240, 32'hffff_ff87, 4'hf);
        expect_store(32'h244, 32'h0000_0087, 4'hf);
        expect_store(32'h248, 32'hffff_8765, 4'hf);
        expect_store(32'h24c, 32'h0000_8765, 4'hf);
        expect_store(32'h250, 32'h1234_5000, 4'hf);
        // only the not taken branches leave a marker
        expect_store(32'h254, 32'h0000_0005, 4'hf);
        expect_store(32'h260, 32'h0000_0005, 4'hf);
        expect_store(32'h264, 32'h0000_0005, 4'hf);
        expect_store(32'h270, 32'h0000_0005, 4'hf);
        expect_store(32'h27c, 32'h0000_00f4, 4'hf);
        expect_store(32'h288, 32'h0000_0108, 4'hf);
        expect_store(32'h28c, 32'h0000_0000, 4'hf);
        expect_store(32'h290, 32'h0000_0005, 4'hf);
        expect_store(32'h29c, 32'h0000_0005, 4'hf);
    endtask

    // counts every write, anything past the table is an error
    always @(i_mem.write_seen) begin
        writes_seen = writes_seen + 1;
        if (writes_seen > n_stores) begin
            $display("unexpected store to %h of data %h at %0t ns, none was left to expect",
                     i_mem.wr_addr, i_mem.wr_data, $time);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    // budget counted from reset release
    initial begin
        @(posedge resetn);
        repeat (prog_len * 40) @(posedge clk);
        $display("watchdog expired, the core stopped storing results");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        prog_len    = 0;
        n_stores    = 0;
        writes_seen = 0;
        build_program();
        build_expected();
        #1;
        // preload after the memory fill at time zero
        for (int i = 0; i < prog_len; i++) begin
            i_mem.mem[i] = prog[i];
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int i = 0; i < n_stores; i++) begin
            @(i_mem.write_seen);
            check_value(i_mem.wr_addr, exp_addr[i], $sformatf("store %0d address", i));
            check_value(i_mem.wr_data, exp_data[i], $sformatf("store %0d data", i));
            check_value({28'b0, i_mem.wr_mask}, {28'b0, exp_mask[i]},
                        $sformatf("store %0d mask", i));
        end
        // give a stray store time to show up
        repeat (40) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: all.f
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
sim/tb_memory.sv
sim/tb_core.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= tb_core
FILELIST ?= all.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
